/* flist.f */
rvPkg.sv
Alu.sv
AluDecoder.sv
BranchUnit.sv
ControlUnit.sv
ImmExtend.sv
RegFile.sv
RiscvCore.sv
RiscvCore_sva.sv
tbRiscvCore.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbRiscvCore
FLIST     ?= flist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no pass result in log"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tbRiscvCore.sv */
`timescale 1ns/1ps

module tbRiscvCore;
    import rvPkg::*;

    localparam int resetCycles = 16;
    localparam int numInstr    = 2000;
    localparam int cycleLimit  = resetCycles + numInstr + 100; // margin over the run length

    logic            clk;
    logic            reset;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] readData;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] dataAddr;
    logic [xlen-1:0] writeData;
    logic            memWrite;

    logic [31:0] prog [256]; // program image, word index pc[9:2]
    logic [31:0] dmem [64];  // data memory seen by the DUT
    logic [31:0] mMem [64];  // model copy of data memory
    logic [31:0] mRegs [32];
    logic [31:0] mPc;
    logic [31:0] rngState;
    int          cycleCount;

    RiscvCore i_RiscvCore (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .readData  (readData),
        .pc        (pc),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .memWrite  (memWrite)
    );

    always #50 clk = ~clk; // 100 ns period

    assign instr    = prog[pc[9:2]];       // same-cycle fetch
    assign readData = dmem[dataAddr[7:2]]; // combinational read

    always @(posedge clk) begin
        if (memWrite) dmem[dataAddr[7:2]] <= writeData; // store lands at the edge
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            abortRun();
        end
    end

    task automatic abortRun();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic logic [31:0] nextRand(); // xorshift32
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [31:0] fillWord(input int idx);
        return 32'h9e37_79b9 * (idx + 1); // every address bit matters
    endfunction

    function automatic logic [31:0] randInstr();
        logic [31:0] r;
        logic [31:0] sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        r    = nextRand();
        sel  = nextRand();
        rd   = {2'b00, r[2:0]}; // x0..x7 only
        rs1  = {2'b00, r[5:3]};
        rs2  = {2'b00, r[8:6]};
        f3   = r[11:9];
        imm  = r[23:12];
        boff = {7'b0, r[15:12], 2'b00} - 13'd16; // -16..+44
        joff = {14'b0, {1'b0, r[15:12]} + 5'd1, 2'b00}; // forward only, 4..64
        if (boff == 13'd0) boff = 13'd8;
        case (sel[3:0])
            4'd0, 4'd1, 4'd2, 4'd3:
                return {1'b0, r[24] & (f3 == 3'b000 || f3 == 3'b101), 5'b0,
                        rs2, rs1, f3, rd, 7'b0110011};
            4'd4, 4'd5, 4'd6: begin
                if (f3 == 3'b001) imm = {7'b0, r[16:12]};                // slli
                if (f3 == 3'b101) imm = {1'b0, r[24], 5'b0, r[16:12]};   // srli/srai
                return {imm, rs1, f3, rd, 7'b0010011};
            end
            4'd7, 4'd8: begin
                imm = {4'b0, r[17:12], 2'b00}; // aligned, below 256
                return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
            end
            4'd9:
                return {4'b0, r[17:12], 2'b00, 5'd0, 3'b010, rd, 7'b0000011};
            4'd10, 4'd11: begin
                if (f3 == 3'b010 || f3 == 3'b011) f3 = {2'b11, f3[0]}; // no such branch
                return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'b1100011};
            end
            4'd12:
                return {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
            4'd13:
                return {2'b00, r[19:12], 2'b00, 5'd0, 3'b000, rd, 7'b1100111};
            4'd14:
                return {r[31:12], rd, 7'b0110111}; // lui
            default:
                return {r[31:12], rd, 7'b0010111}; // auipc
        endcase
    endfunction

    function automatic logic [31:0] computeAlu(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $signed(a) >>> b[4:0] : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // ISA-level step of the reference model, reports the store it makes
    task automatic stepModel(output logic we, output logic [31:0] addr,
                             output logic [31:0] data);
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] iImm;
        logic [31:0] sImm;
        logic [31:0] bImm;
        logic [31:0] uImm;
        logic [31:0] jImm;
        logic [31:0] ea;
        logic [31:0] wb;
        logic [31:0] nextPc;
        logic        wen;
        inst   = prog[mPc[9:2]];
        a      = mRegs[inst[19:15]];
        b      = mRegs[inst[24:20]];
        iImm   = {{20{inst[31]}}, inst[31:20]};
        sImm   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        bImm   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        uImm   = {inst[31:12], 12'h000};
        jImm   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        nextPc = mPc + 32'd4;
        wen    = 1'b0;
        wb     = '0;
        we     = 1'b0;
        addr   = '0;
        data   = '0;
        case (inst[6:0])
            opR: begin
                wb  = computeAlu(inst[14:12], inst[30], a, b);
                wen = 1'b1;
            end
            opI: begin
                wb  = computeAlu(inst[14:12], inst[30] && inst[14:12] == 3'b101, a, iImm);
                wen = 1'b1;
            end
            opLoad: begin
                ea  = a + iImm;
                wb  = mMem[ea[7:2]];
                wen = 1'b1;
            end
            opStore: begin
                ea   = a + sImm;
                we   = 1'b1;
                addr = ea;
                data = b;
                mMem[ea[7:2]] = b;
            end
            opBranch: begin
                if (branchTaken(inst[14:12], a, b)) nextPc = mPc + bImm;
            end
            opJal: begin
                wb     = mPc + 32'd4; // link
                wen    = 1'b1;
                nextPc = mPc + jImm;
            end
            opJalr: begin
                ea     = a + iImm; // target before link write, rd may equal rs1
                nextPc = {ea[31:1], 1'b0};
                wb     = mPc + 32'd4;
                wen    = 1'b1;
            end
            opLui: begin
                wb  = uImm;
                wen = 1'b1;
            end
            opAuipc: begin
                wb  = mPc + uImm;
                wen = 1'b1;
            end
            default: ;
        endcase
        if (wen && inst[11:7] != 5'd0) mRegs[inst[11:7]] = wb;
        mPc = nextPc;
    endtask

    task automatic checkPc(input logic [xlen-1:0] expPc, input logic [xlen-1:0] actPc);
        if (actPc !== expPc) begin
            $display("[ERROR] pc expected %h got %h", expPc, actPc);
            abortRun();
        end
    endtask

    task automatic checkStore(input logic expWe, input logic [xlen-1:0] expAddr,
                              input logic [xlen-1:0] expData, input logic actWe,
                              input logic [xlen-1:0] actAddr, input logic [xlen-1:0] actData);
        if (actWe !== expWe) begin
            $display("[ERROR] memWrite expected %h got %h", expWe, actWe);
            abortRun();
        end else if (expWe && actAddr !== expAddr) begin
            $display("[ERROR] dataAddr expected %h got %h", expAddr, actAddr);
            abortRun();
        end else if (expWe && actData !== expData) begin
            $display("[ERROR] writeData expected %h got %h", expData, actData);
            abortRun();
        end
    endtask

    initial begin
        logic        expWe;
        logic [31:0] expAddr;
        logic [31:0] expData;
        clk        = 1'b0;
        reset      = 1'b1;
        cycleCount = 0;
        rngState   = 32'h918b_f100;
        for (int i = 0; i < 256; i++) prog[i] = randInstr();
        prog[0] = {7'd0, 5'd0, 5'd0, 3'b010, 5'd0, 7'b0100011}; // sw x0, 0(x0) at the reset pc
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fillWord(i);
            mMem[i] = fillWord(i); // model starts from the same image
        end
        for (int i = 0; i < 32; i++) mRegs[i] = '0;
        mPc = '0;

        repeat (resetCycles - 1) begin
            @(negedge clk);
            checkStore(1'b0, '0, '0, memWrite, dataAddr, writeData); // nothing stored in reset
        end
        @(posedge clk);
        #1 reset = 1'b0;

        for (int n = 0; n < numInstr; n++) begin
            @(negedge clk); // mid-cycle, outputs settled
            checkPc(mPc, pc);
            stepModel(expWe, expAddr, expData);
            checkStore(expWe, expAddr, expData, memWrite, dataAddr, writeData);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* RiscvCore_sva.sv */
`timescale 1ns/1ps

module RiscvCoreSva (
    input logic                   clk,
    input logic                   reset,
    input logic [rvPkg::xlen-1:0] pc,
    input logic                   memWrite,
    input logic [rvPkg::xlen-1:0] x0        // register file entry 0
);

    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc %h not word aligned", pc);

    // pc reads zero one edge after reset is seen
    pcResetZero: assert property (@(posedge clk) reset |=> pc == '0)
        else $error("pc %h not cleared by reset", pc);

    noStoreInReset: assert property (@(posedge clk) reset |-> !memWrite)
        else $error("memWrite high during reset");

    x0Zero: assert property (@(posedge clk) disable iff (reset) x0 == '0)
        else $error("x0 holds nonzero value %h", x0);

endmodule

bind RiscvCore RiscvCoreSva i_RiscvCoreSva (
    .clk      (clk),
    .reset    (reset),
    .pc       (pc),
    .memWrite (memWrite),
    .x0       (i_RegFile.regs[0])
);

/* RiscvCore.sv */
`timescale 1ns/1ps

module RiscvCore (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [rvPkg::xlen-1:0] instr,     // fetched at pc, same cycle
    input  logic [rvPkg::xlen-1:0] readData,  // combinational for dataAddr
    output logic [rvPkg::xlen-1:0] pc,
    output logic [rvPkg::xlen-1:0] dataAddr,
    output logic [rvPkg::xlen-1:0] writeData,
    output logic                   memWrite
);
    import rvPkg::*;

    opcodeT          opcode;
    aluCatT          aluCat;
    aluOpT           aluOp;
    logic [1:0]      pcSrc;
    logic [1:0]      resultSrc;
    logic [2:0]      immSrc;
    logic            aluSrc;
    logic            memWriteDec;  // raw decode
    logic            regWriteDec;
    logic            regWrite;     // after reset gating
    logic            branch;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] immExt;
    logic [xlen-1:0] srcB;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] result;
    logic [xlen-1:0] pcPlusFour;
    logic [xlen-1:0] pcPlusImm;    // branch/jal target, auipc value
    logic [xlen-1:0] pcNext;

    assign opcode = opcodeT'(instr[6:0]);

    ControlUnit i_ControlUnit (
        .opcode    (opcode),
        .branch    (branch),
        .pcSrc     (pcSrc),
        .resultSrc (resultSrc),
        .memWrite  (memWriteDec),
        .aluSrc    (aluSrc),
        .immSrc    (immSrc),
        .regWrite  (regWriteDec),
        .aluCat    (aluCat)
    );

    AluDecoder i_AluDecoder (
        .aluCat   (aluCat),
        .funct3   (instr[14:12]),
        .funct7b5 (instr[30]),
        .aluOp    (aluOp)
    );

    RegFile i_RegFile (
        .clk         (clk),
        .reset       (reset),
        .rs1         (instr[19:15]),
        .rs2         (instr[24:20]),
        .rd          (instr[11:7]),
        .writeEnable (regWrite),
        .writeData   (result),
        .rd1         (rd1),
        .rd2         (rd2)
    );

    ImmExtend i_ImmExtend (
        .instr  (instr[31:7]),
        .immSrc (immSrc),
        .immExt (immExt)
    );

    BranchUnit i_BranchUnit (
        .rd1    (rd1),
        .rd2    (rd2),
        .funct3 (instr[14:12]),
        .branch (branch)
    );

    assign srcB = aluSrc ? immExt : rd2;

    Alu i_Alu (
        .a      (rd1),
        .b      (srcB),
        .aluOp  (aluOp),
        .result (aluResult)
    );

    // no stores or reg writes while in reset
    assign memWrite = memWriteDec & ~reset;
    assign regWrite = regWriteDec & ~reset;

    assign dataAddr  = aluResult;
    assign writeData = rd2;

    assign pcPlusFour = pc + 32'd4;
    assign pcPlusImm  = pc + immExt;

    always_comb begin
        case (pcSrc)
            pcTarget: pcNext = pcPlusImm;
            pcJalr:   pcNext = {aluResult[xlen-1:1], 1'b0}; // clear bit 0
            default:  pcNext = pcPlusFour;
        endcase
    end

    always_comb begin
        case (resultSrc)
            resMem:     result = readData;
            resPcPlus4: result = pcPlusFour; // jal/jalr link
            resPcImm:   result = pcPlusImm;
            default:    result = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pcNext; // one instr per clock
        end
    end

endmodule

/* RegFile.sv */
`timescale 1ns/1ps

module RegFile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [4:0]             rs1,
    input  logic [4:0]             rs2,
    input  logic [4:0]             rd,
    input  logic                   writeEnable,
    input  logic [rvPkg::xlen-1:0] writeData,
    output logic [rvPkg::xlen-1:0] rd1,
    output logic [rvPkg::xlen-1:0] rd2
);
    import rvPkg::*;

    logic [xlen-1:0] regs [32]; // x0 entry never written

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (writeEnable && rd != 5'd0) begin
            regs[rd] <= writeData;
        end
    end

    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1]; // x0 reads zero
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* ImmExtend.sv */
`timescale 1ns/1ps

module ImmExtend (
    input  logic [31:7]            instr,
    input  logic [2:0]             immSrc,
    output logic [rvPkg::xlen-1:0] immExt
);
    import rvPkg::*;

    always_comb begin
        case (immSrc)
            immI:    immExt = {{20{instr[31]}}, instr[31:20]};
            immS:    immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB:    immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immU:    immExt = {instr[31:12], 12'b0}; // low bits zero
            immJ:    immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: immExt = '0;
        endcase
    end

endmodule

/* ControlUnit.sv */
`timescale 1ns/1ps

module ControlUnit (
    input  rvPkg::opcodeT opcode,    // instr[6:0]
    input  logic          branch,    // condition from BranchUnit
    output logic [1:0]    pcSrc,
    output logic [1:0]    resultSrc,
    output logic          memWrite,
    output logic          aluSrc,    // 1 selects immediate as alu b
    output logic [2:0]    immSrc,
    output logic          regWrite,
    output rvPkg::aluCatT aluCat     // to AluDecoder
);
    import rvPkg::*;

    always_comb begin
        // alu category
        case (opcode)
            opR:      aluCat = catR;
            opI:      aluCat = catI;
            opLoad:   aluCat = catLoad;
            opStore:  aluCat = catStore;
            opBranch: aluCat = catBranch;
            opJal:    aluCat = catJump;
            opJalr:   aluCat = catJump; // rs1 + imm for target
            opLui:    aluCat = catLui;
            opAuipc:  aluCat = catAuipc;
            default:  aluCat = catR;
        endcase

        // writeback source
        case (opcode)
            opR:     resultSrc = resAlu;
            opI:     resultSrc = resAlu;
            opLoad:  resultSrc = resMem;
            opJal:   resultSrc = resPcPlus4;
            opJalr:  resultSrc = resPcPlus4;
            opLui:   resultSrc = resAlu; // alu passes imm through
            opAuipc: resultSrc = resPcImm;
            default: resultSrc = resAlu;
        endcase

        case (opcode)
            opStore: memWrite = 1'b1;
            default: memWrite = 1'b0;
        endcase

        // alu b operand
        case (opcode)
            opR:      aluSrc = 1'b0;
            opI:      aluSrc = 1'b1;
            opLoad:   aluSrc = 1'b1; // base + offset
            opStore:  aluSrc = 1'b1;
            opBranch: aluSrc = 1'b0; // compares two regs
            opJal:    aluSrc = 1'b1;
            opJalr:   aluSrc = 1'b1;
            opLui:    aluSrc = 1'b1;
            opAuipc:  aluSrc = 1'b1;
            default:  aluSrc = 1'b0;
        endcase

        // immediate format
        case (opcode)
            opI:      immSrc = immI;
            opLoad:   immSrc = immI;
            opJalr:   immSrc = immI;
            opStore:  immSrc = immS;
            opBranch: immSrc = immB;
            opLui:    immSrc = immU;
            opAuipc:  immSrc = immU;
            opJal:    immSrc = immJ;
            default:  immSrc = immI;
        endcase

        case (opcode)
            opR:     regWrite = 1'b1;
            opI:     regWrite = 1'b1;
            opLoad:  regWrite = 1'b1;
            opJal:   regWrite = 1'b1; // link
            opJalr:  regWrite = 1'b1;
            opLui:   regWrite = 1'b1;
            opAuipc: regWrite = 1'b1;
            default: regWrite = 1'b0; // store, branch, unknown
        endcase

        // next pc, branch only redirects when taken
        case (opcode)
            opBranch: pcSrc = branch ? pcTarget : pcPlus4;
            opJal:    pcSrc = pcTarget;
            opJalr:   pcSrc = pcJalr;
            default:  pcSrc = pcPlus4;
        endcase
    end

endmodule

/* BranchUnit.sv */
`timescale 1ns/1ps

module BranchUnit (
    input  logic [rvPkg::xlen-1:0] rd1,
    input  logic [rvPkg::xlen-1:0] rd2,
    input  logic [2:0]             funct3,
    output logic                   branch // condition only, opcode gating in ControlUnit
);

    always_comb begin
        case (funct3)
            3'b000:  branch = (rd1 == rd2);                   // beq
            3'b001:  branch = (rd1 != rd2);                   // bne
            3'b100:  branch = ($signed(rd1) < $signed(rd2));  // blt
            3'b101:  branch = ($signed(rd1) >= $signed(rd2)); // bge
            3'b110:  branch = (rd1 < rd2);                    // bltu
            3'b111:  branch = (rd1 >= rd2);                   // bgeu
            default: branch = 1'b0;
        endcase
    end

endmodule

/* AluDecoder.sv */
`timescale 1ns/1ps

module AluDecoder (
    input  rvPkg::aluCatT aluCat,
    input  logic [2:0]    funct3,
    input  logic          funct7b5, // instr[30]
    output rvPkg::aluOpT  aluOp
);
    import rvPkg::*;

    always_comb begin
        case (aluCat)
            catR, catI: begin
                case (funct3)
                    3'b000:  aluOp = (aluCat == catR && funct7b5) ? aluSub : aluAdd; // addi has no sub
                    3'b001:  aluOp = aluSll;
                    3'b010:  aluOp = aluSlt;
                    3'b011:  aluOp = aluSltu;
                    3'b100:  aluOp = aluXor;
                    3'b101:  aluOp = funct7b5 ? aluSra : aluSrl; // both formats
                    3'b110:  aluOp = aluOr;
                    default: aluOp = aluAnd; // 3'b111
                endcase
            end
            catBranch: aluOp = aluSub;
            catLui:    aluOp = aluPassB;
            default:   aluOp = aluAdd; // load, store, jump, auipc
        endcase
    end

endmodule

/* Alu.sv */
`timescale 1ns/1ps

module Alu (
    input  logic [rvPkg::xlen-1:0] a,      // rs1
    input  logic [rvPkg::xlen-1:0] b,      // rs2 or imm
    input  rvPkg::aluOpT           aluOp,
    output logic [rvPkg::xlen-1:0] result
);
    import rvPkg::*;

    always_comb begin
        case (aluOp)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluSll:   result = a << b[4:0];
            aluSrl:   result = a >> b[4:0];
            aluSra:   result = $signed(a) >>> b[4:0]; // keeps sign
            aluSlt:   result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            aluSltu:  result = {{(xlen-1){1'b0}}, a < b};
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

endmodule

/* rvPkg.sv */
package rvPkg;

    localparam int xlen = 32; // datapath word width

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opR      = 7'b0110011, // reg-reg alu
        opI      = 7'b0010011, // reg-imm alu
        opLoad   = 7'b0000011, // lw
        opStore  = 7'b0100011, // sw
        opBranch = 7'b1100011, // beq..bgeu
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111
    } opcodeT;

    // alu category from main decoder
    typedef enum logic [2:0] {
        catR      = 3'b000,
        catI      = 3'b001,
        catLoad   = 3'b010,
        catStore  = 3'b011,
        catBranch = 3'b100,
        catJump   = 3'b101, // jal and jalr share this
        catLui    = 3'b110,
        catAuipc  = 3'b111
    } aluCatT;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSll   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluSlt   = 4'd8,
        aluSltu  = 4'd9,
        aluPassB = 4'd10 // lui
    } aluOpT;

    // next pc select
    localparam logic [1:0] pcPlus4  = 2'b00;
    localparam logic [1:0] pcTarget = 2'b01; // pc + imm
    localparam logic [1:0] pcJalr   = 2'b11; // (rs1 + imm) & ~1

    // writeback select
    localparam logic [1:0] resAlu     = 2'b00;
    localparam logic [1:0] resMem     = 2'b01;
    localparam logic [1:0] resPcPlus4 = 2'b10; // link value
    localparam logic [1:0] resPcImm   = 2'b11; // auipc

    // immediate format select
    localparam logic [2:0] immI = 3'b000;
    localparam logic [2:0] immS = 3'b001;
    localparam logic [2:0] immB = 3'b010;
    localparam logic [2:0] immU = 3'b011;
    localparam logic [2:0] immJ = 3'b100;

endpackage
